/* rtl/plPkg.sv */
package plPkg;

    typedef logic [31:0] word_t;     // Data, operand and instruction word
    typedef logic [4:0]  regAddr_t;  // Register index
    typedef logic [2:0]  aluOp_t;    // Instruction class for the ALU decoder

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8,
        aluSltu = 4'd9
    } aluCtrl_t;

    localparam aluOp_t aluOpR      = 3'b000;  // Register-register ALU
    localparam aluOp_t aluOpI      = 3'b001;  // Register-immediate ALU
    localparam aluOp_t aluOpBranch = 3'b100;  // Conditional branch
    localparam aluOp_t aluOpJalr   = 3'b101;  // Indirect jump

    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // Branch condition codes in funct3
    localparam logic [2:0] fBeq  = 3'b000;
    localparam logic [2:0] fBne  = 3'b001;
    localparam logic [2:0] fBlt  = 3'b100;
    localparam logic [2:0] fBge  = 3'b101;
    localparam logic [2:0] fBltu = 3'b110;
    localparam logic [2:0] fBgeu = 3'b111;

endpackage

/* rtl/PL_ALUDecode.sv */
module PL_ALUDecode import plPkg::*; (
    input  logic       opcode5,  // Opcode bit 5, set for register-register ops
    input  logic [2:0] funct3,   // Instruction bits 14:12
    input  logic       funct75,  // Instruction bit 30
    input  aluOp_t     ALUop,    // Instruction class from main decode
    output aluCtrl_t   ALUCtrl   // Operation for the ALU
);

    logic rAlt;  // Alternate-op bit, only meaningful for true R-type

    assign rAlt = funct75 & opcode5;

    always_comb begin
        ALUCtrl = aluAdd;  // Default add
        case (ALUop)
            aluOpR: begin
                case ({funct3, rAlt})
                    4'b0000: ALUCtrl = aluAdd;
                    4'b0001: ALUCtrl = aluSub;
                    4'b1000: ALUCtrl = aluXor;
                    4'b1100: ALUCtrl = aluOr;
                    4'b1110: ALUCtrl = aluAnd;
                    4'b0010: ALUCtrl = aluSll;
                    4'b1010: ALUCtrl = aluSrl;
                    4'b1011: ALUCtrl = aluSra;
                    4'b0100: ALUCtrl = aluSlt;
                    4'b0110: ALUCtrl = aluSltu;
                    default: ALUCtrl = aluAdd;
                endcase
            end

            aluOpI: begin
                case (funct3)
                    3'b000: ALUCtrl = aluAdd;   // Addi
                    3'b100: ALUCtrl = aluXor;   // Xori
                    3'b110: ALUCtrl = aluOr;    // Ori
                    3'b111: ALUCtrl = aluAnd;   // Andi
                    3'b001: ALUCtrl = aluSll;   // Slli
                    3'b101: begin
                        // Bit 30 picks arithmetic over logical shift
                        if (funct75) begin
                            ALUCtrl = aluSra;
                        end else begin
                            ALUCtrl = aluSrl;
                        end
                    end
                    3'b010: ALUCtrl = aluSlt;   // Slti
                    3'b011: ALUCtrl = aluSltu;  // Sltiu
                    default: ALUCtrl = aluAdd;
                endcase
            end

            aluOpBranch: begin
                case (funct3)
                    fBeq, fBne, fBlt, fBge: ALUCtrl = aluSub;   // Signed and equality
                    fBltu, fBgeu:           ALUCtrl = aluSltu;  // Unsigned compares
                    default:                ALUCtrl = aluAdd;
                endcase
            end

            aluOpJalr: ALUCtrl = aluAdd;  // Target is rs1 + imm

            default: ALUCtrl = aluAdd;
        endcase
    end

endmodule

/* rtl/plInstrDecode.sv */
module plInstrDecode import plPkg::*; (
    input  word_t      instr,       // Instruction word
    input  logic       instrValid,  // Instruction strobe
    output regAddr_t   rs1Addr,     // Source 1 index
    output regAddr_t   rs2Addr,     // Source 2 index
    output regAddr_t   rdAddr,      // Destination index
    output logic       decValid,    // Supported instruction present
    output logic       useImm,      // Operand B from immediate
    output logic       regWrite,    // Result goes to register file
    output logic       isBranch,
    output logic       isJump,
    output aluCtrl_t   aluCtrl,     // ALU operation
    output word_t      imm,         // Sign-extended immediate
    output logic [2:0] funct3       // Function field, branch condition
);

    logic [6:0] opcode;
    aluOp_t     aluOp;
    logic       known;    // Opcode is one of the four supported
    logic       isRType;
    logic       isIType;
    word_t      immI;
    word_t      immB;

    assign opcode  = instr[6:0];
    assign rdAddr  = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];  // Don't care for I-type

    // Immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        aluOp    = aluOpR;
        known    = 1'b0;
        isRType  = 1'b0;
        isIType  = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        case (opcode)
            opOp: begin
                aluOp   = aluOpR;
                known   = 1'b1;
                isRType = 1'b1;
            end
            opOpImm: begin
                aluOp   = aluOpI;
                known   = 1'b1;
                isIType = 1'b1;
            end
            opBranch: begin
                aluOp    = aluOpBranch;
                known    = 1'b1;
                isBranch = 1'b1;
            end
            opJalr: begin
                aluOp  = aluOpJalr;
                known  = 1'b1;
                isJump = 1'b1;
            end
            default: begin
                known = 1'b0;  // Dropped, no result
            end
        endcase
    end

    assign decValid = instrValid & known;
    assign regWrite = (isRType | isIType) & (rdAddr != '0);  // x0 writes suppressed
    assign useImm   = isIType | isJump;
    assign imm      = isBranch ? immB : immI;  // Branch offset has no PC to use

    PL_ALUDecode PL_ALUDecode_i (
        .opcode5 (instr[5]),
        .funct3  (funct3),
        .funct75 (instr[30]),
        .ALUop   (aluOp),
        .ALUCtrl (aluCtrl)
    );

endmodule

/* rtl/plRegFile.sv */
module plRegFile import plPkg::*; #(
    parameter int numRegs = 32  // 32 for RV32I, 16 for RV32E
) (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    input  regAddr_t wbAddr,
    input  logic     wbEnable,
    input  word_t    wbData,
    output word_t    rs1Data,
    output word_t    rs2Data
);

    localparam int idxW = $clog2(numRegs);

    word_t           regs [numRegs];
    logic [idxW-1:0] rs1Idx;
    logic [idxW-1:0] rs2Idx;
    logic [idxW-1:0] wbIdx;

    assign rs1Idx = rs1Addr[idxW-1:0];  // Upper bits ignored for RV32E
    assign rs2Idx = rs2Addr[idxW-1:0];
    assign wbIdx  = wbAddr[idxW-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEnable && wbIdx != '0) begin
            regs[wbIdx] <= wbData;
        end
    end

    // Zero register first, then write-through from execute stage
    always_comb begin
        if (rs1Idx == '0) begin
            rs1Data = '0;
        end else if (wbEnable && wbIdx == rs1Idx) begin
            rs1Data = wbData;  // Bypass
        end else begin
            rs1Data = regs[rs1Idx];
        end

        if (rs2Idx == '0) begin
            rs2Data = '0;
        end else if (wbEnable && wbIdx == rs2Idx) begin
            rs2Data = wbData;  // Bypass
        end else begin
            rs2Data = regs[rs2Idx];
        end
    end

endmodule

/* rtl/plIdExReg.sv */
module plIdExReg import plPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       decValid,
    input  aluCtrl_t   aluCtrl,
    input  word_t      imm,
    input  logic       useImm,
    input  regAddr_t   rdAddr,
    input  logic       regWrite,
    input  logic       isBranch,
    input  logic       isJump,
    input  logic [2:0] funct3,
    input  word_t      rs1Data,
    input  word_t      rs2Data,
    output logic       exValid,     // Instruction in execute
    output aluCtrl_t   exAluCtrl,
    output word_t      exOpA,       // rs1 value
    output word_t      exOpB,       // rs2 or immediate
    output word_t      exRs2,       // rs2 value for branch compare
    output regAddr_t   exRd,
    output logic       exRegWrite,
    output logic       exBranch,
    output logic       exJump,
    output logic [2:0] exFunct3
);

    // Control bits, qualified by decValid
    always_ff @(posedge clk) begin
        if (reset) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exBranch   <= 1'b0;
            exJump     <= 1'b0;
        end else begin
            exValid    <= decValid;
            exRegWrite <= decValid & regWrite;
            exBranch   <= decValid & isBranch;
            exJump     <= decValid & isJump;
        end
    end

    // Operands and fields
    always_ff @(posedge clk) begin
        exAluCtrl <= aluCtrl;
        exOpA     <= rs1Data;
        exOpB     <= useImm ? imm : rs2Data;  // Operand B mux at capture
        exRs2     <= rs2Data;
        exRd      <= rdAddr;
        exFunct3  <= funct3;
    end

endmodule

/* rtl/plAlu.sv */
module plAlu import plPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       exValid,
    input  aluCtrl_t   exAluCtrl,
    input  word_t      exOpA,
    input  word_t      exOpB,
    input  word_t      exRs2,
    input  regAddr_t   exRd,
    input  logic       exRegWrite,
    input  logic       exBranch,
    input  logic       exJump,
    input  logic [2:0] exFunct3,
    output logic       wbEnable,     // Same-cycle register write
    output regAddr_t   wbAddr,
    output word_t      wbData,
    output word_t      result,       // Registered ALU result
    output regAddr_t   resultRd,
    output logic       resultValid,  // One-cycle pulse per instruction
    output logic       branchTaken,
    output logic       jumpValid
);

    word_t       aluResult;
    logic [4:0]  shamt;
    logic [32:0] cmpDiff;   // rs1 - rs2 with borrow in bit 32
    logic        eq;
    logic        lt;
    logic        ltu;
    logic        overflow;
    logic        taken;

    assign shamt = exOpB[4:0];  // Low 5 bits only

    always_comb begin
        case (exAluCtrl)
            aluAdd:  aluResult = exOpA + exOpB;
            aluSub:  aluResult = exOpA - exOpB;
            aluAnd:  aluResult = exOpA & exOpB;
            aluOr:   aluResult = exOpA | exOpB;
            aluXor:  aluResult = exOpA ^ exOpB;
            aluSll:  aluResult = exOpA << shamt;
            aluSrl:  aluResult = exOpA >> shamt;
            aluSra:  aluResult = word_t'($signed(exOpA) >>> shamt);
            aluSlt:  aluResult = {31'd0, $signed(exOpA) < $signed(exOpB)};
            aluSltu: aluResult = {31'd0, exOpA < exOpB};
            default: aluResult = '0;
        endcase
    end

    // Branch comparator on the register value of rs2
    assign cmpDiff  = {1'b0, exOpA} - {1'b0, exRs2};
    assign eq       = (cmpDiff[31:0] == '0);
    assign overflow = (exOpA[31] ^ exRs2[31]) & (exOpA[31] ^ cmpDiff[31]);
    assign lt       = cmpDiff[31] ^ overflow;  // Sign corrected for overflow
    assign ltu      = cmpDiff[32];             // Borrow out

    always_comb begin
        case (exFunct3)
            fBeq:    taken = eq;
            fBne:    taken = ~eq;
            fBlt:    taken = lt;
            fBge:    taken = ~lt;
            fBltu:   taken = ltu;
            fBgeu:   taken = ~ltu;
            default: taken = 1'b0;
        endcase
    end

    assign wbEnable = exValid & exRegWrite;
    assign wbAddr   = exRd;
    assign wbData   = aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            branchTaken <= 1'b0;
            jumpValid   <= 1'b0;
        end else begin
            resultValid <= exValid;
            branchTaken <= exValid & exBranch & taken;
            jumpValid   <= exValid & exJump;
        end
    end

    always_ff @(posedge clk) begin
        if (exValid) begin  // Hold last result otherwise
            result   <= aluResult;
            resultRd <= exRd;
        end
    end

endmodule

/* rtl/plExecCore.sv */
module plExecCore import plPkg::*; #(
    parameter int numRegs = 32  // Register count, 16 for RV32E
) (
    input  logic     clk,
    input  logic     reset,
    input  word_t    instr,
    input  logic     instrValid,
    output word_t    result,
    output regAddr_t resultRd,
    output logic     resultValid,
    output logic     branchTaken,
    output logic     jumpValid
);

    regAddr_t   rs1Addr;
    regAddr_t   rs2Addr;
    regAddr_t   rdAddr;
    word_t      rs1Data;
    word_t      rs2Data;
    logic       decValid;
    logic       useImm;
    logic       regWrite;
    logic       isBranch;
    logic       isJump;
    aluCtrl_t   aluCtrl;
    word_t      imm;
    logic [2:0] funct3;

    logic       exValid;     // Execute stage
    aluCtrl_t   exAluCtrl;
    word_t      exOpA;
    word_t      exOpB;
    word_t      exRs2;
    regAddr_t   exRd;
    logic       exRegWrite;
    logic       exBranch;
    logic       exJump;
    logic [2:0] exFunct3;

    logic       wbEnable;    // Writeback from execute
    regAddr_t   wbAddr;
    word_t      wbData;

    plInstrDecode plInstrDecode_i (
        .instr      (instr),
        .instrValid (instrValid),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rdAddr     (rdAddr),
        .decValid   (decValid),
        .useImm     (useImm),
        .regWrite   (regWrite),
        .isBranch   (isBranch),
        .isJump     (isJump),
        .aluCtrl    (aluCtrl),
        .imm        (imm),
        .funct3     (funct3)
    );

    plRegFile #(
        .numRegs (numRegs)
    ) plRegFile_i (
        .clk      (clk),
        .reset    (reset),
        .rs1Addr  (rs1Addr),
        .rs2Addr  (rs2Addr),
        .wbAddr   (wbAddr),
        .wbEnable (wbEnable),
        .wbData   (wbData),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data)
    );

    plIdExReg plIdExReg_i (
        .clk        (clk),
        .reset      (reset),
        .decValid   (decValid),
        .aluCtrl    (aluCtrl),
        .imm        (imm),
        .useImm     (useImm),
        .rdAddr     (rdAddr),
        .regWrite   (regWrite),
        .isBranch   (isBranch),
        .isJump     (isJump),
        .funct3     (funct3),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .exValid    (exValid),
        .exAluCtrl  (exAluCtrl),
        .exOpA      (exOpA),
        .exOpB      (exOpB),
        .exRs2      (exRs2),
        .exRd       (exRd),
        .exRegWrite (exRegWrite),
        .exBranch   (exBranch),
        .exJump     (exJump),
        .exFunct3   (exFunct3)
    );

    plAlu plAlu_i (
        .clk         (clk),
        .reset       (reset),
        .exValid     (exValid),
        .exAluCtrl   (exAluCtrl),
        .exOpA       (exOpA),
        .exOpB       (exOpB),
        .exRs2       (exRs2),
        .exRd        (exRd),
        .exRegWrite  (exRegWrite),
        .exBranch    (exBranch),
        .exJump      (exJump),
        .exFunct3    (exFunct3),
        .wbEnable    (wbEnable),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .result      (result),
        .resultRd    (resultRd),
        .resultValid (resultValid),
        .branchTaken (branchTaken),
        .jumpValid   (jumpValid)
    );

endmodule

/* tests/plExecCoreTb.sv */
module plExecCoreTb;

    typedef struct packed {
        logic [31:0] word;       // Instruction word
        logic        valid;      // instrValid for this cycle
        logic        expPulse;   // resultValid expected
        logic        chkData;    // Result and rd compared
        logic [31:0] expResult;
        logic [4:0]  expRd;
        logic        expTaken;
        logic        expJump;
    } entry_t;

    localparam int maxEntries = 96;
    localparam int drainLimit = 40;  // Cycles allowed for the last results

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        instrValid;
    logic [31:0] result;
    logic [4:0]  resultRd;
    logic        resultValid;
    logic        branchTaken;
    logic        jumpValid;

    entry_t      tbl [maxEntries];
    logic [31:0] refRegs [32];  // Reference register model
    int          numEntries;
    int          expectedPulses;
    int          pulseCount;
    int          errors;
    int          curIdx;        // Table entry on the DUT inputs
    int          stage1;        // Entries in flight, -1 for none
    int          stage2;
    int          due;
    entry_t      monEntry;
    entry_t      drvEntry;
    int          waitCycles;
    logic        timedOut;

    plExecCore #(
        .numRegs (32)
    ) plExecCore_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instrValid  (instrValid),
        .result      (result),
        .resultRd    (resultRd),
        .resultValid (resultValid),
        .branchTaken (branchTaken),
        .jumpValid   (jumpValid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] encodeR(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] encodeI(input int imm, input int f3, input int rd,
                                            input int rs1, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] encodeB(input int f3, input int rs1, input int rs2,
                                            input int offset);
        logic [12:0] off;
        off = offset[12:0];
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    // RV32I integer op, alt is bit 30 where it applies
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? (a - b) : (a + b);
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic pushEntry(input logic [31:0] word, input logic valid);
        entry_t e;
        e = '0;
        e.word = word;
        e.valid = valid;
        tbl[numEntries] = e;
        numEntries++;
    endtask

    // Fills the expected fields and steps the register model
    task automatic predictEntry(input int idx);
        entry_t      e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] val;
        logic [4:0]  rd;
        logic [2:0]  f3;
        e = tbl[idx];
        rd = e.word[11:7];
        f3 = e.word[14:12];
        a = refRegs[e.word[19:15]];
        b = refRegs[e.word[24:20]];
        immI = {{20{e.word[31]}}, e.word[31:20]};
        if (e.valid) begin
            case (e.word[6:0])
                7'h33: begin
                    val = aluRef(f3, e.word[30], a, b);
                    e.expPulse = 1'b1;
                    e.chkData = 1'b1;
                    e.expResult = val;
                    e.expRd = rd;
                    if (rd != 5'd0) refRegs[rd] = val;
                end
                7'h13: begin
                    val = aluRef(f3, (f3 == 3'd5) && e.word[30], a, immI);
                    e.expPulse = 1'b1;
                    e.chkData = 1'b1;
                    e.expResult = val;
                    e.expRd = rd;
                    if (rd != 5'd0) refRegs[rd] = val;
                end
                7'h63: begin
                    e.expPulse = 1'b1;  // Taken flag only
                    e.expTaken = branchRef(f3, a, b);
                end
                7'h67: begin
                    e.expPulse = 1'b1;  // Target out, no write
                    e.chkData = 1'b1;
                    e.expResult = a + immI;
                    e.expRd = rd;
                    e.expJump = 1'b1;
                end
                default: ;  // Unsupported, dropped
            endcase
        end
        tbl[idx] = e;
    endtask

    task automatic buildTable();
        numEntries = 0;
        // Constants, including negatives and a write to x0
        pushEntry(encodeI(100, 0, 1, 0, 7'h13), 1'b1);
        pushEntry(encodeI(-7, 0, 2, 0, 7'h13), 1'b1);
        pushEntry(encodeI(2047, 0, 3, 0, 7'h13), 1'b1);
        pushEntry(encodeI(-2048, 0, 4, 0, 7'h13), 1'b1);
        pushEntry(encodeI(55, 0, 0, 0, 7'h13), 1'b1);    // x0 stays zero
        pushEntry(encodeR(0, 0, 5, 0, 1), 1'b1);         // x0 + x1
        pushEntry(encodeI(35, 0, 6, 0, 7'h13), 1'b1);    // Shift amount 35 -> 3
        pushEntry(encodeI(-1, 0, 7, 0, 7'h13), 1'b1);
        pushEntry(encodeR(0, 0, 9, 1, 2), 1'b0);         // Idle, strobe low
        pushEntry(encodeR(0, 0, 9, 1, 2), 1'b0);
        // R-type
        pushEntry(encodeR(0, 0, 8, 1, 2), 1'b1);         // Add
        pushEntry(encodeR(32, 0, 9, 2, 1), 1'b1);        // Sub
        pushEntry(encodeR(0, 7, 10, 2, 3), 1'b1);
        pushEntry(encodeR(0, 6, 11, 2, 4), 1'b1);
        pushEntry(encodeR(0, 4, 12, 7, 1), 1'b1);
        pushEntry(encodeR(0, 1, 13, 2, 6), 1'b1);
        pushEntry(encodeR(0, 5, 14, 2, 6), 1'b1);        // Srl
        pushEntry(encodeR(32, 5, 15, 2, 6), 1'b1);       // Sra
        pushEntry(encodeR(0, 2, 16, 2, 1), 1'b1);
        pushEntry(encodeR(0, 3, 17, 2, 1), 1'b1);
        pushEntry(encodeR(0, 2, 18, 1, 2), 1'b1);
        pushEntry(encodeR(0, 3, 19, 1, 2), 1'b1);
        pushEntry(32'h0000_0000, 1'b0);
        // I-type
        pushEntry(encodeI(85, 4, 20, 2, 7'h13), 1'b1);
        pushEntry(encodeI(-16, 6, 21, 1, 7'h13), 1'b1);
        pushEntry(encodeI(240, 7, 22, 7, 7'h13), 1'b1);
        pushEntry(encodeI(4, 1, 23, 1, 7'h13), 1'b1);
        pushEntry(encodeI(8, 5, 24, 2, 7'h13), 1'b1);    // Srli
        pushEntry(encodeI('h408, 5, 25, 2, 7'h13), 1'b1); // Srai, bit 30 set
        pushEntry(encodeI(1, 2, 26, 7, 7'h13), 1'b1);    // Slti on -1
        pushEntry(encodeI(1, 3, 27, 7, 7'h13), 1'b1);    // Sltiu on -1
        pushEntry(encodeI(-1, 3, 28, 1, 7'h13), 1'b1);
        // Dependent chain, no gaps
        pushEntry(encodeI(5, 0, 29, 0, 7'h13), 1'b1);
        pushEntry(encodeR(0, 0, 29, 29, 29), 1'b1);
        pushEntry(encodeR(32, 0, 30, 29, 1), 1'b1);
        pushEntry(encodeR(0, 4, 31, 30, 29), 1'b1);
        pushEntry(encodeI(1, 0, 29, 31, 7'h13), 1'b1);
        // Overflow operands, 0x80000000 and 0x7fffffff
        pushEntry(encodeI(1, 0, 28, 0, 7'h13), 1'b1);
        pushEntry(encodeI(31, 1, 28, 28, 7'h13), 1'b1);
        pushEntry(encodeI(-1, 0, 27, 28, 7'h13), 1'b1);
        // Branches
        pushEntry(encodeB(0, 1, 1, 16), 1'b1);           // Beq taken
        pushEntry(encodeB(0, 1, 2, -8), 1'b1);
        pushEntry(encodeB(1, 1, 2, 16), 1'b1);           // Bne
        pushEntry(encodeB(1, 3, 3, 16), 1'b1);
        pushEntry(encodeB(4, 2, 1, 32), 1'b1);           // Blt
        pushEntry(encodeB(4, 1, 2, 32), 1'b1);
        pushEntry(encodeB(4, 28, 27, -16), 1'b1);        // Blt with overflow
        pushEntry(encodeB(5, 1, 2, 8), 1'b1);            // Bge
        pushEntry(encodeB(5, 2, 2, 8), 1'b1);
        pushEntry(encodeB(5, 2, 1, 8), 1'b1);
        pushEntry(encodeB(5, 27, 28, 8), 1'b1);
        pushEntry(32'h0000_0000, 1'b0);
        pushEntry(encodeB(6, 1, 2, 64), 1'b1);           // Bltu
        pushEntry(encodeB(6, 2, 1, 64), 1'b1);
        pushEntry(encodeB(6, 28, 27, 64), 1'b1);
        pushEntry(encodeB(7, 2, 1, -4), 1'b1);           // Bgeu
        pushEntry(encodeB(7, 1, 2, -4), 1'b1);
        pushEntry(encodeB(7, 28, 27, -4), 1'b1);
        pushEntry(encodeR(0, 0, 20, 1, 2), 1'b1);        // Registers untouched
        // Jalr and unsupported opcodes
        pushEntry(encodeI(12, 0, 5, 1, 7'h67), 1'b1);
        pushEntry(encodeR(0, 0, 21, 5, 0), 1'b1);        // x5 not written
        pushEntry(encodeI(-4, 0, 0, 2, 7'h67), 1'b1);
        pushEntry({20'h12345, 5'd5, 7'h37}, 1'b1);       // Lui, dropped
        pushEntry(encodeI(0, 2, 5, 1, 7'h03), 1'b1);     // Load, dropped
        pushEntry(encodeR(0, 0, 22, 5, 0), 1'b1);
    endtask

    task automatic reportMismatch(input string field, input int idx,
                                  input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("Fail at time %0t: entry %0d %s is %h, expected %h",
                 $time, idx, field, got, exp);
    endtask

    // Outputs sampled on the falling edge two cycles after the entry went in
    always @(negedge clk) begin
        if (!reset) begin
            due = stage2;
            if (resultValid === 1'b1) pulseCount++;
            if (resultValid !== (due >= 0)) begin
                reportMismatch("resultValid", due, resultValid, due >= 0);
            end else if (due >= 0) begin
                monEntry = tbl[due];
                if (monEntry.chkData && result !== monEntry.expResult) begin
                    reportMismatch("result", due, result, monEntry.expResult);
                end
                if (monEntry.chkData && resultRd !== monEntry.expRd) begin
                    reportMismatch("resultRd", due, resultRd, monEntry.expRd);
                end
                if (branchTaken !== monEntry.expTaken) begin
                    reportMismatch("branchTaken", due, branchTaken, monEntry.expTaken);
                end
                if (jumpValid !== monEntry.expJump) begin
                    reportMismatch("jumpValid", due, jumpValid, monEntry.expJump);
                end
            end else if (branchTaken !== 1'b0 || jumpValid !== 1'b0) begin
                reportMismatch("flags without result", -1, {branchTaken, jumpValid}, 0);
            end
        end
        stage2 = stage1;
        if (curIdx >= 0 && tbl[curIdx].expPulse) begin
            stage1 = curIdx;
        end else begin
            stage1 = -1;
        end
    end

    initial begin
        reset = 1'b1;
        instr = '0;
        instrValid = 1'b0;
        curIdx = -1;
        stage1 = -1;
        stage2 = -1;
        errors = 0;
        pulseCount = 0;
        expectedPulses = 0;
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        buildTable();
        for (int i = 0; i < numEntries; i++) begin
            predictEntry(i);
            if (tbl[i].expPulse) expectedPulses++;
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < numEntries; i++) begin
            @(posedge clk);
            drvEntry = tbl[i];
            instr <= drvEntry.word;
            instrValid <= drvEntry.valid;
            curIdx <= i;
        end
        @(posedge clk);
        instr <= '0;
        instrValid <= 1'b0;
        curIdx <= -1;

        // Drain the pipeline
        waitCycles = 0;
        while ((pulseCount < expectedPulses || stage1 >= 0 || stage2 >= 0)
               && waitCycles < drainLimit) begin
            @(posedge clk);
            waitCycles++;
        end
        timedOut = (pulseCount < expectedPulses) || (stage1 >= 0) || (stage2 >= 0);
        if (timedOut) begin
            errors++;
            $display("Timeout: results stopped arriving after %0d cycles of waiting",
                     waitCycles);
        end

        $display("Errors: %0d, result pulses: %0d of %0d expected",
                 errors, pulseCount, expectedPulses);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/plPkg.sv
rtl/PL_ALUDecode.sv
rtl/plInstrDecode.sv
rtl/plRegFile.sv
rtl/plIdExReg.sv
rtl/plAlu.sv
rtl/plExecCore.sv
tests/plExecCoreTb.sv

/* Bender.yml */
package:
  name: pl_exec_core

sources:
  - rtl/plPkg.sv
  - rtl/PL_ALUDecode.sv
  - rtl/plInstrDecode.sv
  - rtl/plRegFile.sv
  - rtl/plIdExReg.sv
  - rtl/plAlu.sv
  - rtl/plExecCore.sv
  - target: test
    files:
      - tests/plExecCoreTb.sv
